/* Makefile */
# Verilator build and run of the L1 cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TRACE     ?= tests/l1_cache_trace.txt
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard rtl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+rtl
rtl/l1_cache_pkg.sv
rtl/cache_array_if.sv
rtl/cache_array.sv
rtl/way_select.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
tests/tb_clock.sv
tests/tb_l1_cache.sv

/* rtl/cache_array.sv */
`default_nettype none
`include "l1_cache_consts.svh"

module cache_array (
    input  logic         CLK,
    input  logic         nRST,
    cache_array_if.array port
);

    localparam int BLOCK_BYTES = $bits(l1_cache_pkg::block_mask_t);

    // payload storage
    l1_cache_pkg::block_t data_q [`L1_N_SETS][`L1_ASSOC];
    l1_cache_pkg::tag_t   tag_q  [`L1_N_SETS][`L1_ASSOC];

    // line state bits, one per way
    logic [`L1_ASSOC-1:0] valid_q [`L1_N_SETS];
    logic [`L1_ASSOC-1:0] dirty_q [`L1_N_SETS];

    // tag always replaced on a write
    // data only in the enabled byte lanes
    always_ff @(posedge CLK) begin
        if (port.wr_en) begin
            tag_q[port.set][port.wr_way] <= port.wr_tag;
            for (int b = 0; b < BLOCK_BYTES; b++) begin
                if (port.wr_mask[b]) begin
                    data_q[port.set][port.wr_way][b*8 +: 8] <= port.wr_block[b*8 +: 8];
                end
            end
        end
    end

    // valid and dirty come up cleared
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L1_N_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (port.wr_en) begin
            valid_q[port.set][port.wr_way] <= port.wr_valid;
            dirty_q[port.set][port.wr_way] <= port.wr_dirty;
        end
    end

    // read side, straight from set
    always_comb begin
        for (int w = 0; w < `L1_ASSOC; w++) begin
            port.rd_block[w] = data_q[port.set][w];
            port.rd_tag[w]   = tag_q[port.set][w];
        end
    end

    assign port.rd_valid = valid_q[port.set];
    assign port.rd_dirty = dirty_q[port.set];

    // a dirty line is always a valid one
    a_dirty_valid: assert property (
        @(posedge CLK) disable iff (!nRST)
        (port.wr_en && port.wr_dirty) |-> port.wr_valid
    ) else $error("dirty write to invalid line, set %0d way %0d", port.set, port.wr_way);

endmodule

`default_nettype wire

/* rtl/cache_array_if.sv */
`default_nettype none
`include "l1_cache_consts.svh"

interface cache_array_if;

    // selected set, both ways read at once
    l1_cache_pkg::set_idx_t                    set;
    l1_cache_pkg::block_t [`L1_ASSOC-1:0]      rd_block;
    l1_cache_pkg::tag_t [`L1_ASSOC-1:0]        rd_tag;
    logic [`L1_ASSOC-1:0]                      rd_valid;
    logic [`L1_ASSOC-1:0]                      rd_dirty;

    // write request, applied at the clock edge
    logic                                      wr_en;
    l1_cache_pkg::way_idx_t                    wr_way;
    l1_cache_pkg::block_t                      wr_block;
    l1_cache_pkg::block_mask_t                 wr_mask;
    l1_cache_pkg::tag_t                        wr_tag;
    logic                                      wr_valid;
    logic                                      wr_dirty;

    // controller also needs the read side for writebacks
    modport ctrl (
        output set, wr_en, wr_way, wr_block, wr_mask, wr_tag, wr_valid, wr_dirty,
        input  rd_block, rd_tag, rd_valid, rd_dirty
    );
    modport array (
        input  set, wr_en, wr_way, wr_block, wr_mask, wr_tag, wr_valid, wr_dirty,
        output rd_block, rd_tag, rd_valid, rd_dirty
    );
    modport lookup (
        input  set, rd_block, rd_tag, rd_valid, rd_dirty
    );

endinterface

`default_nettype wire

/* rtl/cache_ctrl.sv */
`default_nettype none
`include "l1_cache_consts.svh"

module cache_ctrl (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      ren,
    input  logic                      wen,
    input  logic                      flush,
    input  l1_cache_pkg::word_t       addr,
    input  l1_cache_pkg::word_t       wdata,
    input  l1_cache_pkg::byte_en_t    byte_en,
    output l1_cache_pkg::word_t       rdata,
    output logic                      busy,
    output logic                      flush_done,
    output logic                      cache_miss,
    output logic                      mem_req,
    output logic                      mem_we,
    output l1_cache_pkg::word_t       mem_addr,
    output l1_cache_pkg::block_t      mem_wdata,
    input  l1_cache_pkg::block_t      mem_rdata,
    input  logic                      mem_ack,
    cache_array_if.ctrl               port,
    input  logic                      hit,
    input  l1_cache_pkg::way_idx_t    hit_way,
    input  l1_cache_pkg::way_idx_t    victim_way,
    input  logic                      victim_dirty,
    input  l1_cache_pkg::tag_t        victim_tag,
    output logic                      touch
);

    localparam int OFF_BITS = `L1_WORD_OFF_BITS + `L1_BYTE_OFF_BITS;
    localparam int SET_LSB  = OFF_BITS;
    localparam int BE_BITS  = `L1_WORD_BITS / 8;

    l1_cache_pkg::cache_state_t state_q, state_d;
    // decoded request address
    l1_cache_pkg::tag_t         req_tag;
    l1_cache_pkg::set_idx_t     req_set;
    l1_cache_pkg::word_off_t    req_woff;
    // shared walk counter for CLEAR and FLUSH
    l1_cache_pkg::set_idx_t     walk_set;
    l1_cache_pkg::way_idx_t     walk_way;
    logic                       walk_last, walk_step;
    logic                       flush_pend;
    // memory transfer wanted in this state
    logic                       mem_xfer, xfer_done, line_dirty;

    assign req_tag  = addr[`L1_WORD_BITS-1 -: `L1_TAG_BITS];
    assign req_set  = addr[SET_LSB +: `L1_SET_BITS];
    assign req_woff = addr[`L1_BYTE_OFF_BITS +: `L1_WORD_OFF_BITS];

    assign walk_last = (int'(walk_set) == `L1_N_SETS - 1) && (int'(walk_way) == `L1_ASSOC - 1);
    assign xfer_done = mem_req && mem_ack;
    assign line_dirty = port.rd_valid[walk_way] && port.rd_dirty[walk_way];

    // hit word, only meaningful while busy is low
    assign rdata = port.rd_block[hit_way][req_woff*`L1_WORD_BITS +: `L1_WORD_BITS];

    always_comb begin
        state_d        = state_q;
        busy           = 1'b1;
        touch          = 1'b0;
        flush_done     = 1'b0;
        cache_miss     = 1'b0;
        walk_step      = 1'b0;
        mem_xfer       = 1'b0;
        mem_we         = 1'b0;
        mem_addr       = {req_tag, req_set, {OFF_BITS{1'b0}}};
        mem_wdata      = port.rd_block[victim_way];
        port.set       = req_set;
        port.wr_en     = 1'b0;
        port.wr_way    = victim_way;
        port.wr_block  = mem_rdata;
        port.wr_mask   = '0;
        port.wr_tag    = req_tag;
        port.wr_valid  = 1'b0;
        port.wr_dirty  = 1'b0;
        case (state_q)
            l1_cache_pkg::CLEAR: begin
                // invalidate one line per cycle
                port.set    = walk_set;
                port.wr_en  = 1'b1;
                port.wr_way = walk_way;
                port.wr_tag = '0;
                walk_step   = 1'b1;
                if (walk_last) state_d = l1_cache_pkg::READY;
            end
            l1_cache_pkg::READY: begin
                if (flush || flush_pend) begin
                    state_d = l1_cache_pkg::FLUSH;
                end else if (!(ren || wen)) begin
                    busy = 1'b0;
                end else if (hit) begin
                    busy  = 1'b0;
                    touch = 1'b1;
                    // write hit merges bytes, keeps tag, marks dirty
                    if (wen) begin
                        port.wr_en    = 1'b1;
                        port.wr_way   = hit_way;
                        port.wr_block = {`L1_BLOCK_WORDS{wdata}};
                        port.wr_mask  = l1_cache_pkg::block_mask_t'(byte_en) << (req_woff * BE_BITS);
                        port.wr_valid = 1'b1;
                        port.wr_dirty = 1'b1;
                    end
                end else if (victim_dirty) begin
                    state_d = l1_cache_pkg::WRITEBACK;
                end else begin
                    state_d = l1_cache_pkg::FETCH;
                end
            end
            l1_cache_pkg::WRITEBACK: begin
                // victim block back to its own address
                mem_xfer  = 1'b1;
                mem_we    = 1'b1;
                mem_addr  = {victim_tag, req_set, {OFF_BITS{1'b0}}};
                if (xfer_done) state_d = l1_cache_pkg::FETCH;
            end
            l1_cache_pkg::FETCH: begin
                mem_xfer = 1'b1;
                // fill whole victim way while ack is high
                if (xfer_done) begin
                    port.wr_en    = 1'b1;
                    port.wr_mask  = '1;
                    port.wr_valid = 1'b1;
                    cache_miss    = 1'b1;
                    state_d       = l1_cache_pkg::READY;
                end
            end
            l1_cache_pkg::FLUSH: begin
                port.set    = walk_set;
                port.wr_way = walk_way;
                port.wr_tag = port.rd_tag[walk_way];
                mem_addr    = {port.rd_tag[walk_way], walk_set, {OFF_BITS{1'b0}}};
                mem_wdata   = port.rd_block[walk_way];
                mem_xfer    = line_dirty;
                mem_we      = line_dirty;
                // clean lines drop at once, dirty ones after their writeback
                if (!line_dirty || xfer_done) begin
                    port.wr_en = 1'b1;
                    walk_step  = 1'b1;
                    if (walk_last) begin
                        flush_done = 1'b1;
                        state_d    = l1_cache_pkg::READY;
                    end
                end
            end
            default: state_d = l1_cache_pkg::CLEAR;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q    <= l1_cache_pkg::CLEAR;
            walk_set   <= '0;
            walk_way   <= '0;
            flush_pend <= 1'b0;
            mem_req    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (walk_step && walk_last) begin
                {walk_set, walk_way} <= '0;
            end else if (walk_step) begin
                {walk_set, walk_way} <= {walk_set, walk_way} + 1'b1;
            end
            // flush seen during a miss waits for READY
            if (flush_done) begin
                flush_pend <= 1'b0;
            end else if (flush) begin
                flush_pend <= 1'b1;
            end
            // four-phase: drop on ack, raise only once ack is low
            if (xfer_done) begin
                mem_req <= 1'b0;
            end else if (mem_xfer && !mem_req && !mem_ack) begin
                mem_req <= 1'b1;
            end
        end
    end

    // request fields hold steady until memory acks
    a_req_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (mem_req && !mem_ack) |=> ($stable(mem_addr) && $stable(mem_we))
    ) else $error("mem_addr or mem_we changed while mem_req waited for mem_ack");

    // memory back-pressure keeps the processor stalled
    a_busy_on_mem: assert property (
        @(posedge CLK) disable iff (!nRST)
        mem_req |-> busy
    ) else $error("busy low with mem_req high, state %s", state_q.name());

endmodule

`default_nettype wire

/* rtl/l1_cache.sv */
`default_nettype none
`include "l1_cache_consts.svh"

module l1_cache (
    input  logic                   CLK,
    input  logic                   nRST,
    // processor side
    input  logic                   ren,
    input  logic                   wen,
    input  l1_cache_pkg::word_t    addr,
    input  l1_cache_pkg::word_t    wdata,
    input  l1_cache_pkg::byte_en_t byte_en,
    output l1_cache_pkg::word_t    rdata,
    output logic                   busy,
    input  logic                   flush,
    output logic                   flush_done,
    output logic                   cache_miss,
    // memory side, one block per transfer
    output logic                   mem_req,
    output logic                   mem_we,
    output l1_cache_pkg::word_t    mem_addr,
    output l1_cache_pkg::block_t   mem_wdata,
    input  l1_cache_pkg::block_t   mem_rdata,
    input  logic                   mem_ack
);

    cache_array_if array_port ();

    l1_cache_pkg::tag_t     req_tag;
    logic                   hit, touch, victim_dirty;
    l1_cache_pkg::way_idx_t hit_way, victim_way;
    l1_cache_pkg::tag_t     victim_tag;

    // lookup tag, top bits of the request
    assign req_tag = addr[`L1_WORD_BITS-1 -: `L1_TAG_BITS];

    cache_array u_array (
        .CLK  (CLK),
        .nRST (nRST),
        .port (array_port.array)
    );

    way_select u_way_select (
        .CLK          (CLK),
        .nRST         (nRST),
        .port         (array_port.lookup),
        .req_tag      (req_tag),
        .touch        (touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_ctrl u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .ren          (ren),
        .wen          (wen),
        .flush        (flush),
        .addr         (addr),
        .wdata        (wdata),
        .byte_en      (byte_en),
        .rdata        (rdata),
        .busy         (busy),
        .flush_done   (flush_done),
        .cache_miss   (cache_miss),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_ack      (mem_ack),
        .port         (array_port.ctrl),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .touch        (touch)
    );

endmodule

`default_nettype wire

/* rtl/l1_cache_consts.svh */
`ifndef L1_CACHE_CONSTS_SVH
`define L1_CACHE_CONSTS_SVH

// data word width
`define L1_WORD_BITS      32
// words per block
`define L1_BLOCK_WORDS    2
// sets and ways
`define L1_N_SETS         8
`define L1_ASSOC          2

// address field widths, low to high
`define L1_BYTE_OFF_BITS  2
`define L1_WORD_OFF_BITS  1
`define L1_SET_BITS       3

// tag takes whatever is left of the word
`define L1_TAG_BITS       (`L1_WORD_BITS - `L1_SET_BITS - `L1_WORD_OFF_BITS - `L1_BYTE_OFF_BITS)

// address layout: tag | set | word offset | byte offset
// set starts right above both offset fields
// tag starts right above the set field

`endif

/* rtl/l1_cache_pkg.sv */
`default_nettype none
`include "l1_cache_consts.svh"

package l1_cache_pkg;

    // one data word
    typedef logic [`L1_WORD_BITS-1:0] word_t;
    // whole block, word 0 in the low bits
    typedef logic [`L1_BLOCK_WORDS*`L1_WORD_BITS-1:0] block_t;

    // address fields
    typedef logic [`L1_TAG_BITS-1:0] tag_t;
    typedef logic [`L1_SET_BITS-1:0] set_idx_t;
    typedef logic [`L1_WORD_OFF_BITS-1:0] word_off_t;

    // way number
    typedef logic [$clog2(`L1_ASSOC)-1:0] way_idx_t;

    // byte enables, one word and one block
    typedef logic [`L1_WORD_BITS/8-1:0] byte_en_t;
    typedef logic [`L1_BLOCK_WORDS*`L1_WORD_BITS/8-1:0] block_mask_t;

    // controller states
    // CLEAR is the walk after reset
    typedef enum logic [2:0] {
        CLEAR,
        READY,
        WRITEBACK,
        FETCH,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

/* rtl/way_select.sv */
`default_nettype none
`include "l1_cache_consts.svh"

module way_select (
    input  logic                   CLK,
    input  logic                   nRST,
    cache_array_if.lookup          port,
    input  l1_cache_pkg::tag_t     req_tag,
    input  logic                   touch,
    output logic                   hit,
    output l1_cache_pkg::way_idx_t hit_way,
    output l1_cache_pkg::way_idx_t victim_way,
    output logic                   victim_dirty,
    output l1_cache_pkg::tag_t     victim_tag
);

    // per-way tag match
    logic [`L1_ASSOC-1:0] way_match;
    // last way touched, per set
    l1_cache_pkg::way_idx_t last_used [`L1_N_SETS];
    l1_cache_pkg::way_idx_t set_last;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L1_ASSOC; w++) begin
            way_match[w] = port.rd_valid[w] && (port.rd_tag[w] == req_tag);
            if (way_match[w]) begin
                hit_way = l1_cache_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit = |way_match;

    // only completed hits move the last-used bit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L1_N_SETS; s++) begin
                last_used[s] <= '0;
            end
        end else if (touch) begin
            last_used[port.set] <= hit_way;
        end
    end

    // victim is the way after the last used one, wrapping
    assign set_last   = last_used[port.set];
    assign victim_way = (int'(set_last) == `L1_ASSOC - 1) ? '0 : set_last + 1'b1;

    assign victim_dirty = port.rd_dirty[victim_way];
    assign victim_tag   = port.rd_tag[victim_way];

    // a tag lives in at most one way of a set
    a_single_hit: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0(way_match)
    ) else $error("tag hit in more than one way, set %0d", port.set);

endmodule

`default_nettype wire

/* tests/l1_cache_trace.txt */
// columns: op_addr_data_byteen in hex; op 1 read (data is expected rdata), 2 write,
// 3 flush, 4 memory word check (data is expected), 5 miss count so far (in addr), 0 end
// first touch of set 1
1_00000008_c0de0008_0
5_00000001_00000000_0
// other word, then same word again
1_0000000c_c0de000c_0
1_00000008_c0de0008_0
5_00000001_00000000_0
// bytes 0 and 2 only
2_00000008_aabbccdd_5
1_00000008_c0bb00dd_0
5_00000001_00000000_0
// second tag fills the other way
1_00000048_c0de0048_0
// third tag evicts the dirty block
1_00000088_c0de0088_0
4_00000008_c0bb00dd_0
4_0000000c_c0de000c_0
// most recent survivor still hits
1_00000048_c0de0048_0
5_00000003_00000000_0
// refill from memory shows the written bytes
1_00000008_c0bb00dd_0
5_00000004_00000000_0
// write miss allocates, then merges
2_00000104_11223344_f
1_00000104_11223344_0
1_00000100_c0de0100_0
4_00000104_c0de0104_0
2_00000208_99000000_8
2_00000030_0000ffff_3
5_00000007_00000000_0
3_00000000_00000000_0
4_00000104_11223344_0
4_00000100_c0de0100_0
4_00000208_99de0208_0
4_00000030_c0deffff_0
4_00000034_c0de0034_0
// flushed lines miss again
1_00000104_11223344_0
1_00000030_c0deffff_0
5_00000009_00000000_0
0_00000000_00000000_0

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic CLK
);
    timeunit 1ns;
    timeprecision 100ps;

    // half of the 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

endmodule

`default_nettype wire

/* tests/tb_l1_cache.sv */
`default_nettype none
`include "l1_cache_consts.svh"

module tb_l1_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam TRACE_FILE        = "tests/l1_cache_trace.txt";
    localparam int TRACE_LEN     = 64;
    localparam int MEM_WORDS     = 1024;
    localparam int TIMEOUT       = 400;
    // one cycle per line of every set
    localparam int CLEAR_CYCLES  = `L1_N_SETS * `L1_ASSOC;

    // trace operation codes
    localparam logic [3:0] OP_END    = 4'h0;
    localparam logic [3:0] OP_READ   = 4'h1;
    localparam logic [3:0] OP_WRITE  = 4'h2;
    localparam logic [3:0] OP_FLUSH  = 4'h3;
    localparam logic [3:0] OP_MEMCHK = 4'h4;
    localparam logic [3:0] OP_MISSES = 4'h5;

    // memory model handshake phases
    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_WAIT = 2'd1;
    localparam logic [1:0] PH_ACK  = 2'd2;

    logic                   CLK, nRST;
    logic                   ren, wen, flush;
    l1_cache_pkg::word_t    addr, wdata, rdata;
    l1_cache_pkg::byte_en_t byte_en;
    logic                   busy, flush_done, cache_miss;
    logic                   mem_req, mem_we, mem_ack;
    l1_cache_pkg::word_t    mem_addr;
    l1_cache_pkg::block_t   mem_wdata, mem_rdata;

    // op | addr | data | byte_en
    logic [71:0]            trace_mem [TRACE_LEN];
    l1_cache_pkg::word_t    mem_words [MEM_WORDS];
    logic [1:0]             mem_phase;
    logic [9:0]             lo_idx, hi_idx;
    int                     delay_left;
    int                     seed;
    int                     miss_pulses, flush_pulses, errors;

    tb_clock u_clock (.CLK(CLK));

    l1_cache uut (
        .CLK        (CLK),
        .nRST       (nRST),
        .ren        (ren),
        .wen        (wen),
        .addr       (addr),
        .wdata      (wdata),
        .byte_en    (byte_en),
        .rdata      (rdata),
        .busy       (busy),
        .flush      (flush),
        .flush_done (flush_done),
        .cache_miss (cache_miss),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

    // word slots of the addressed block
    assign lo_idx = {mem_addr[11:3], 1'b0};
    assign hi_idx = {mem_addr[11:3], 1'b1};

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input l1_cache_pkg::word_t got,
                            input l1_cache_pkg::word_t expected);
        if (got !== expected) begin
            errors++;
            $display("ERR time=%0t %s: got %h, expected %h", $time, name, got, expected);
            stop_run();
        end
    endtask

    // memory model, four-phase, random ack delay of 0 to 7 cycles
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            seed = 32'hd5f0;
            mem_ack    <= 1'b0;
            mem_rdata  <= '0;
            mem_phase  <= PH_IDLE;
            delay_left <= 0;
            // word at byte address a holds a xor c0de0000
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_words[i] <= l1_cache_pkg::word_t'(i * 4) ^ 32'hc0de0000;
            end
        end else begin
            case (mem_phase)
                PH_IDLE: begin
                    if (mem_req && !mem_ack) begin
                        delay_left <= $random(seed) & 7;
                        mem_phase  <= PH_WAIT;
                    end
                end
                PH_WAIT: begin
                    if (delay_left == 0) begin
                        if (mem_addr[31:12] != '0) begin
                            $display("memory request at %h lies outside the model", mem_addr);
                            stop_run();
                        end
                        mem_ack <= 1'b1;
                        if (mem_we) begin
                            mem_words[lo_idx] <= mem_wdata[31:0];
                            mem_words[hi_idx] <= mem_wdata[63:32];
                        end else begin
                            mem_rdata <= {mem_words[hi_idx], mem_words[lo_idx]};
                        end
                        mem_phase <= PH_ACK;
                    end else begin
                        delay_left <= delay_left - 1;
                    end
                end
                PH_ACK: begin
                    // ack drops only after the cache drops req
                    if (!mem_req) begin
                        mem_ack   <= 1'b0;
                        mem_phase <= PH_IDLE;
                    end
                end
                default: mem_phase <= PH_IDLE;
            endcase
        end
    end

    // pulse counters
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            miss_pulses  <= 0;
            flush_pulses <= 0;
        end else begin
            if (cache_miss) miss_pulses <= miss_pulses + 1;
            if (flush_done) flush_pulses <= flush_pulses + 1;
        end
    end

    task automatic wait_while_busy(input string what);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        while (busy) begin
            if (cycles == TIMEOUT) begin
                $display("timeout: %s request still busy after %0d cycles", what, TIMEOUT);
                stop_run();
            end
            cycles++;
            @(posedge CLK);
        end
    endtask

    // busy must cover the whole walk, memory stays idle
    task automatic check_clear_walk();
        int busy_cycles;
        busy_cycles = 0;
        @(posedge CLK);
        while (busy) begin
            check_eq("mem_req", l1_cache_pkg::word_t'(mem_req), '0);
            if (busy_cycles == TIMEOUT) begin
                $display("timeout: clearing walk did not end after %0d cycles", TIMEOUT);
                stop_run();
            end
            busy_cycles++;
            @(posedge CLK);
        end
        check_eq("busy cycles after reset", l1_cache_pkg::word_t'(busy_cycles), CLEAR_CYCLES);
    endtask

    task automatic cpu_read(input l1_cache_pkg::word_t a, input l1_cache_pkg::word_t expected);
        @(posedge CLK);
        ren  <= 1'b1;
        addr <= a;
        wait_while_busy("read");
        // rdata valid in the cycle busy was low
        check_eq($sformatf("rdata @%h", a), rdata, expected);
        ren <= 1'b0;
    endtask

    task automatic cpu_write(input l1_cache_pkg::word_t a, input l1_cache_pkg::word_t d,
                             input l1_cache_pkg::byte_en_t be);
        @(posedge CLK);
        wen     <= 1'b1;
        addr    <= a;
        wdata   <= d;
        byte_en <= be;
        wait_while_busy("write");
        wen <= 1'b0;
    endtask

    task automatic run_flush();
        int cycles;
        int pulses_before;
        cycles = 0;
        pulses_before = flush_pulses;
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        while (!flush_done) begin
            if (cycles == TIMEOUT) begin
                $display("timeout: no flush_done within %0d cycles", TIMEOUT);
                stop_run();
            end
            cycles++;
            @(posedge CLK);
        end
        // a second pulse would show up here
        repeat (2) @(posedge CLK);
        check_eq("flush_done pulses", l1_cache_pkg::word_t'(flush_pulses - pulses_before), 1);
        check_eq("busy", l1_cache_pkg::word_t'(busy), '0);
    endtask

    task automatic run_entry(input logic [71:0] entry);
        logic [3:0]             op;
        l1_cache_pkg::word_t    a, d;
        l1_cache_pkg::byte_en_t be;
        op = entry[71:68];
        a  = entry[67:36];
        d  = entry[35:4];
        be = entry[3:0];
        case (op)
            OP_READ:   cpu_read(a, d);
            OP_WRITE:  cpu_write(a, d, be);
            OP_FLUSH:  run_flush();
            OP_MEMCHK: check_eq($sformatf("mem_words[%h]", a), mem_words[a[11:2]], d);
            OP_MISSES: begin
                // let the counter settle
                @(posedge CLK);
                check_eq("cache_miss pulses", l1_cache_pkg::word_t'(miss_pulses), a);
            end
            default: begin
                $display("trace entry with unknown operation code %h", op);
                stop_run();
            end
        endcase
    endtask

    initial begin
        int n;
        errors  = 0;
        nRST    <= 1'b0;
        ren     <= 1'b0;
        wen     <= 1'b0;
        flush   <= 1'b0;
        addr    <= '0;
        wdata   <= '0;
        byte_en <= '0;
        // unused slots read as end of trace
        for (int i = 0; i < TRACE_LEN; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh(TRACE_FILE, trace_mem);
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        check_clear_walk();
        n = 0;
        while (n < TRACE_LEN && trace_mem[n][71:68] != OP_END) begin
            run_entry(trace_mem[n]);
            n++;
        end
        repeat (4) @(posedge CLK);
        if (errors == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire
